//--- cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path and pc width.
`define CPU_XLEN 32

// architectural register count.
`define CPU_NUM_REGS 32

// register index width.
`define CPU_REG_ADDR_W 5

// pc of the first accepted instruction.
`define CPU_PC_RESET 32'h0000_0000

// pc increment per accepted instruction.
`define CPU_PC_STEP 32'd4

`endif

//--- cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    // major opcodes handled by the core.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    // alu operations.
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // decoded instruction, as held between decode and the alu.
    typedef struct packed {
        logic                       valid;
        alu_op_e                    alu_op;
        logic [`CPU_REG_ADDR_W-1:0] rs1;
        logic [`CPU_REG_ADDR_W-1:0] rs2;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic                       use_imm;
        logic                       spare;
        logic [`CPU_XLEN-1:0]       imm;
        logic [`CPU_XLEN-1:0]       pc;
    } dec_op_t;

    // completed instruction, also the register file write port.
    typedef struct packed {
        logic                       valid;
        logic [`CPU_XLEN-1:0]       pc;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [`CPU_XLEN-1:0]       data;
    } complete_t;

endpackage

//--- instr_decode.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module instr_decode (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    instr_valid,
    input  logic [31:0]             instr,
    output cpu_pkg::dec_op_t        dec_op
);

    logic [`CPU_XLEN-1:0] pc_q;
    cpu_pkg::opcode_e     opcode;
    logic [2:0]           funct3;
    logic                 funct7_b30;
    logic [`CPU_XLEN-1:0] imm_i;
    logic                 legal;
    logic                 use_imm;
    cpu_pkg::alu_op_e     alu_op;
    cpu_pkg::dec_op_t     dec_d;

    // instruction fields.
    assign opcode     = cpu_pkg::opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign funct7_b30 = instr[30];

    // sign-extended i-type immediate.
    assign imm_i = {{(`CPU_XLEN-12){instr[31]}}, instr[31:20]};

    // opcode class.
    always_comb begin
        legal   = 1'b1;
        use_imm = 1'b0;
        case (opcode)
            cpu_pkg::OPC_OP:     use_imm = 1'b0;
            cpu_pkg::OPC_OP_IMM: use_imm = 1'b1;
            default:             legal   = 1'b0;
        endcase
    end

    // funct3 / funct7 to alu op.
    // no subi, so bit 30 only selects sub on register-register ops.
    always_comb begin
        case (funct3)
            3'b000:  alu_op = (funct7_b30 && !use_imm) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b001:  alu_op = cpu_pkg::ALU_SLL;
            3'b010:  alu_op = cpu_pkg::ALU_SLT;
            3'b011:  alu_op = cpu_pkg::ALU_SLTU;
            3'b100:  alu_op = cpu_pkg::ALU_XOR;
            3'b101:  alu_op = funct7_b30 ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  alu_op = cpu_pkg::ALU_OR;
            default: alu_op = cpu_pkg::ALU_AND;
        endcase
    end

    // next decoded op.
    always_comb begin
        dec_d.valid   = legal;
        dec_d.alu_op  = alu_op;
        dec_d.rs1     = instr[19:15];
        dec_d.rs2     = instr[24:20];
        dec_d.rd      = instr[11:7];
        dec_d.use_imm = use_imm;
        dec_d.spare   = 1'b0;
        dec_d.imm     = imm_i;
        dec_d.pc      = pc_q;
    end

    // fetch pc and decode register.
    // pc steps on every accepted word, illegal ones too.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc_q   <= `CPU_PC_RESET;
            dec_op <= '0;
        end else if (instr_valid) begin
            pc_q   <= pc_q + `CPU_PC_STEP;
            dec_op <= dec_d;
        end else begin
            dec_op.valid <= 1'b0;
        end
    end

endmodule

//--- reg_file.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [`CPU_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`CPU_REG_ADDR_W-1:0] rs2_addr,
    input  cpu_pkg::complete_t         wr,
    output logic [`CPU_XLEN-1:0]       rs1_data,
    output logic [`CPU_XLEN-1:0]       rs2_data
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NUM_REGS];
    logic                 wr_en;
    logic                 rs1_hit;
    logic                 rs2_hit;

    // x0 is never written.
    assign wr_en = wr.valid && (wr.rd != '0);

    // the completion register holds the newest write, so reads see it.
    assign rs1_hit = wr_en && (wr.rd == rs1_addr);
    assign rs2_hit = wr_en && (wr.rd == rs2_addr);

    assign rs1_data = (rs1_addr == '0) ? '0 : (rs1_hit ? wr.data : regs[rs1_addr]);
    assign rs2_data = (rs2_addr == '0) ? '0 : (rs2_hit ? wr.data : regs[rs2_addr]);

    // architectural state.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd] <= wr.data;
        end
    end

endmodule

//--- alu_exec.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module alu_exec (
    input  logic                 clk,
    input  logic                 rstn,
    input  cpu_pkg::dec_op_t     dec_op,
    input  logic [`CPU_XLEN-1:0] rs1_data,
    input  logic [`CPU_XLEN-1:0] rs2_data,
    output cpu_pkg::complete_t   complete
);

    logic [`CPU_XLEN-1:0]         op_a;
    logic [`CPU_XLEN-1:0]         op_b;
    logic [$clog2(`CPU_XLEN)-1:0] shamt;
    logic                         lt_signed;
    logic                         lt_unsigned;
    logic [`CPU_XLEN-1:0]         result;

    // operand select.
    assign op_a = rs1_data;
    assign op_b = dec_op.use_imm ? dec_op.imm : rs2_data;

    // low bits only, also for the immediate shifts.
    assign shamt = op_b[$clog2(`CPU_XLEN)-1:0];

    // compares.
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (dec_op.alu_op)
            cpu_pkg::ALU_ADD:  result = op_a + op_b;
            cpu_pkg::ALU_SUB:  result = op_a - op_b;
            cpu_pkg::ALU_SLL:  result = op_a << shamt;
            cpu_pkg::ALU_SLT:  result = {{(`CPU_XLEN-1){1'b0}}, lt_signed};
            cpu_pkg::ALU_SLTU: result = {{(`CPU_XLEN-1){1'b0}}, lt_unsigned};
            cpu_pkg::ALU_XOR:  result = op_a ^ op_b;
            cpu_pkg::ALU_SRL:  result = op_a >> shamt;
            cpu_pkg::ALU_SRA:  result = $signed(op_a) >>> shamt;
            cpu_pkg::ALU_OR:   result = op_a | op_b;
            cpu_pkg::ALU_AND:  result = op_a & op_b;
            default:           result = '0;
        endcase
    end

    // completion register.
    // also feeds the register file write port.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            complete <= '0;
        end else begin
            complete.valid <= dec_op.valid;
            complete.pc    <= dec_op.pc;
            complete.rd    <= dec_op.rd;
            complete.data  <= result;
        end
    end

endmodule

//--- cpu_core.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpu_core (
    input  logic               clk,
    input  logic               rstn,
    input  logic               instr_valid,
    input  logic [31:0]        instr,
    output cpu_pkg::complete_t complete
);

    cpu_pkg::dec_op_t     dec_op;
    logic [`CPU_XLEN-1:0] rs1_data;
    logic [`CPU_XLEN-1:0] rs2_data;

    // fetch pc and decode.
    instr_decode decode_i (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_op      (dec_op)
    );

    // read addresses come straight from the decode register.
    reg_file reg_file_i (
        .clk      (clk),
        .rstn     (rstn),
        .rs1_addr (dec_op.rs1),
        .rs2_addr (dec_op.rs2),
        .wr       (complete),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu_exec alu_exec_i (
        .clk      (clk),
        .rstn     (rstn),
        .dec_op   (dec_op),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .complete (complete)
    );

endmodule

//--- tb_cpu_core.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module tb_cpu_core;

    localparam int NUM_INSTR       = 2000;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_MARGIN = 10;
    localparam int CLK_PERIOD      = 100;

    // rv32i major opcodes.
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    logic               clk;
    logic               rstn;
    logic               instr_valid;
    logic [31:0]        instr;
    cpu_pkg::complete_t complete;

    // reference model state.
    logic [`CPU_XLEN-1:0] model_regs [`CPU_NUM_REGS];
    logic [`CPU_XLEN-1:0] model_pc;
    logic [31:0]          rng_state;
    cpu_pkg::complete_t   exp_q [$];

    cpu_core dut_i (
        .clk         (clk),
        .rstn        (rstn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .complete    (complete)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // mostly x0..x7, so back-to-back dependencies are common.
    function automatic logic [4:0] pick_reg(input logic [31:0] r);
        if (r[3:0] != 4'h0) begin
            return {2'b00, r[6:4]};
        end else begin
            return r[11:7];
        end
    endfunction

    // alu rules of the isa for op and op-imm.
    function automatic logic [31:0] alu_model(input logic [2:0] funct3, input logic alt,
                                              input logic is_imm, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] res;
        sh = b[4:0];
        case (funct3)
            3'd0: res = (alt && !is_imm) ? a - b : a + b;
            3'd1: res = a << sh;
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (alt) begin
                    res = $signed(a) >>> sh;
                end else begin
                    res = a >> sh;
                end
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        return res;
    endfunction

    task automatic make_instr(output logic v, output logic [31:0] w);
        logic [31:0] r;
        logic [6:0]  opc;
        draw_random(r);
        v = (r[1:0] != 2'b00);
        draw_random(w);
        draw_random(r);
        if (r[3:0] == 4'h0) begin
            // illegal opcode, never one of the two kept classes.
            opc = r[10:4];
            if (opc == OPCODE_OP || opc == OPCODE_OP_IMM) begin
                opc = opc ^ 7'b1000000;
            end
        end else if (r[4]) begin
            opc = OPCODE_OP_IMM;
        end else begin
            opc = OPCODE_OP;
        end
        w[6:0] = opc;
        draw_random(r);
        w[11:7] = pick_reg(r);
        draw_random(r);
        w[19:15] = pick_reg(r);
        if (opc == OPCODE_OP) begin
            draw_random(r);
            w[24:20] = pick_reg(r);
        end
    endtask

    // runs one word through the model in program order.
    task automatic model_step(input logic v, input logic [31:0] w,
                              output cpu_pkg::complete_t e);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        is_imm;
        e = '0;
        if (v) begin
            is_imm = (w[6:0] == OPCODE_OP_IMM);
            if (w[6:0] == OPCODE_OP || is_imm) begin
                imm = {{20{w[31]}}, w[31:20]};
                a = model_regs[w[19:15]];
                b = is_imm ? imm : model_regs[w[24:20]];
                e.valid = 1'b1;
                e.pc    = model_pc;
                e.rd    = w[11:7];
                e.data  = alu_model(w[14:12], w[30], is_imm, a, b);
                if (w[11:7] != 5'd0) begin
                    model_regs[w[11:7]] = e.data;
                end
            end
            model_pc = model_pc + `CPU_PC_STEP;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Errors found");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // main sequence.
    initial begin
        cpu_pkg::complete_t exp_entry;
        logic [31:0]        word;
        logic               drive_valid;
        rstn        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        rng_state   = 32'h9fdc;
        model_pc    = `CPU_PC_RESET;
        for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        for (int n = 0; n < NUM_INSTR; n++) begin
            @(posedge clk);
            make_instr(drive_valid, word);
            model_step(drive_valid, word, exp_entry);
            exp_q.push_back(exp_entry);
            instr_valid <= drive_valid;
            instr       <= word;
        end
        // let the last instructions drain.
        repeat (2) begin
            @(posedge clk);
            exp_q.push_back('0);
            instr_valid <= 1'b0;
            instr       <= '0;
        end
        @(posedge clk);
        $display("No errors");
        $finish;
    end

    // a word driven at edge k completes after edge k+2, so three entries in flight.
    always @(negedge clk) begin
        cpu_pkg::complete_t exp_entry;
        exp_entry = '0;
        if (exp_q.size() == 3) begin
            exp_entry = exp_q.pop_front();
        end
        if (complete.valid !== exp_entry.valid) begin
            if (exp_entry.valid) begin
                $display("no completion at %0t for instruction at pc %h", $time, exp_entry.pc);
            end else begin
                $display("unexpected completion at %0t while none was expected", $time);
            end
            $display("Errors found");
            $fatal(1, "completion stream out of step with the model");
        end else if (exp_entry.valid) begin
            check_value("complete.pc", complete.pc, exp_entry.pc);
            check_value("complete.rd", {27'd0, complete.rd}, {27'd0, exp_entry.rd});
            check_value("complete.data", complete.data, exp_entry.data);
        end
    end

    // watchdog.
    initial begin
        #((RESET_CYCLES + NUM_INSTR + WATCHDOG_MARGIN) * CLK_PERIOD);
        $display("watchdog expired before the instruction sequence finished");
        $display("Errors found");
        $fatal(1, "simulation did not finish in time");
    end

endmodule

//--- cpu_core.f
+incdir+.
cpu_pkg.sv
instr_decode.sv
reg_file.sv
alu_exec.sv
cpu_core.sv
tb_cpu_core.sv

//--- Makefile
# Verilator build for the RV32I integer core and its testbench.

VERILATOR ?= verilator
TOP       ?= tb_cpu_core
FILELIST  ?= cpu_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
BUILD_JOBS ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell sed -n '/^[^+]/p' $(FILELIST)) cpu_settings.svh
	$(VERILATOR) --binary $(VFLAGS) -j $(BUILD_JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)

# the exit status of the simulation is the pass or fail result.
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
